/* Makefile */
# Verilator build and run for the rv32Core testbench

VERILATOR ?= verilator
TOP       ?= tbRv32Core
FILELIST  ?= rv32Core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* coreCtlPkg.sv */
`default_nettype none

package coreCtlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpT;

    // first ALU operand comes from rs1 or from the PC
    typedef enum logic {
        srcAReg,
        srcAPc
    } srcASelT;

    // second ALU operand comes from rs2 or from the immediate
    typedef enum logic {
        srcBReg,
        srcBImm
    } srcBSelT;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcPlus4,
        wbImm
    } wbSelT;

    typedef enum logic [1:0] {
        pcNext,
        pcBranch,
        pcJump
    } pcSelT;

endpackage

`default_nettype wire

/* decodeIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface decodeIf
    import rvIsaPkg::*, coreCtlPkg::*;
();

    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    imm;
    aluOpT   aluOp;
    srcASelT srcASel;
    srcBSelT srcBSel;
    wbSelT   wbSel;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    isBranch;
    logic    isJump;
    // branch condition select
    funct3T  funct3;

    modport producer (
        output rs1, rs2, rd, imm, aluOp, srcASel, srcBSel, wbSel,
        output regWrite, memRead, memWrite, isBranch, isJump, funct3
    );

    modport consumer (
        input rs1, rs2, rd, imm, aluOp, srcASel, srcBSel, wbSel,
        input regWrite, memRead, memWrite, isBranch, isJump, funct3
    );

endinterface

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module execUnit
    import rvIsaPkg::*, coreCtlPkg::*;
(
    input  wire              rst,
    decodeIf.consumer        ctl,
    input  wordT             pc,
    input  wordT             pcPlus4,
    input  wordT             rs1Val,
    input  wordT             rs2Val,
    input  wordT             dataRd,
    output logic             regWe,
    output wordT             wbData,
    output wordT             dataAddr,
    output wordT             dataWr,
    output logic             dataWe,
    output logic             dataRe,
    output logic             branchTaken,
    output wordT             jumpTarget
);

    wordT       srcA;
    wordT       srcB;
    wordT       aluResult;
    logic [4:0] shamt;
    logic       isEq;
    logic       isLt;
    logic       isLtu;
    logic       cond;

    assign srcA  = (ctl.srcASel == srcAPc) ? pc : rs1Val;
    assign srcB  = (ctl.srcBSel == srcBImm) ? ctl.imm : rs2Val;
    assign shamt = srcB[4:0];

    always_comb begin
        case (ctl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluSll:  aluResult = srcA << shamt;
            aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSltu: aluResult = {31'b0, srcA < srcB};
            aluXor:  aluResult = srcA ^ srcB;
            aluSrl:  aluResult = srcA >> shamt;
            aluSra:  aluResult = $signed(srcA) >>> shamt;
            aluOr:   aluResult = srcA | srcB;
            aluAnd:  aluResult = srcA & srcB;
            default: aluResult = srcA + srcB;
        endcase
    end

    // branches compare the two register values directly, the ALU is not involved
    assign isEq  = (rs1Val == rs2Val);
    assign isLt  = ($signed(rs1Val) < $signed(rs2Val));
    assign isLtu = (rs1Val < rs2Val);

    always_comb begin
        case (ctl.funct3)
            f3Beq:   cond = isEq;
            f3Bne:   cond = !isEq;
            f3Blt:   cond = isLt;
            f3Bge:   cond = !isLt;
            f3Bltu:  cond = isLtu;
            f3Bgeu:  cond = !isLtu;
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = ctl.isBranch && cond;

    // for JALR the ALU adds rs1 and the immediate, and bit 0 is dropped
    assign jumpTarget = {aluResult[31:1], 1'b0};

    assign dataAddr = aluResult;
    assign dataWr   = rs2Val;

    assign regWe  = ctl.regWrite && !rst;
    assign dataWe = ctl.memWrite && !rst;
    assign dataRe = ctl.memRead && !rst;

    always_comb begin
        case (ctl.wbSel)
            wbAlu:     wbData = aluResult;
            wbMem:     wbData = dataRd;
            wbPcPlus4: wbData = pcPlus4;
            wbImm:     wbData = ctl.imm;
            default:   wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import rvIsaPkg::*, coreCtlPkg::*;
(
    input  wordT             instr,
    decodeIf.producer        ctl
);

    opcodeT opcode;
    funct3T funct3;
    wordT   immI;
    wordT   immS;
    wordT   immB;
    wordT   immU;
    wordT   immJ;

    // alt selects SUB or SRA where the funct3 allows it
    function automatic aluOpT aluFromFunct(input funct3T f3, input logic alt);
        aluOpT op;
        case (f3)
            f3AddSub: op = alt ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = alt ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            f3And:    op = aluAnd;
            default:  op = aluAdd;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign ctl.rs1    = instr[19:15];
    assign ctl.rs2    = instr[24:20];
    assign ctl.rd     = instr[11:7];
    assign ctl.funct3 = funct3;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctl.imm      = immI;
        ctl.aluOp    = aluAdd;
        ctl.srcASel  = srcAReg;
        ctl.srcBSel  = srcBImm;
        ctl.wbSel    = wbAlu;
        ctl.regWrite = 1'b0;
        ctl.memRead  = 1'b0;
        ctl.memWrite = 1'b0;
        ctl.isBranch = 1'b0;
        ctl.isJump   = 1'b0;
        case (opcode)
            opcOp: begin
                ctl.srcBSel  = srcBReg;
                ctl.aluOp    = aluFromFunct(funct3, instr[funct7Alt]);
                ctl.regWrite = 1'b1;
            end
            opcOpImm: begin
                // ADDI has no subtract form, so bit 30 only matters for shifts
                ctl.aluOp    = aluFromFunct(funct3, (funct3 == f3SrlSra) && instr[funct7Alt]);
                ctl.regWrite = 1'b1;
            end
            opcLoad: begin
                if (funct3 == f3Word) begin
                    ctl.memRead  = 1'b1;
                    ctl.wbSel    = wbMem;
                    ctl.regWrite = 1'b1;
                end
            end
            opcStore: begin
                ctl.imm = immS;
                if (funct3 == f3Word) begin
                    ctl.memWrite = 1'b1;
                end
            end
            opcBranch: begin
                ctl.imm      = immB;
                ctl.isBranch = 1'b1;
            end
            opcJal: begin
                ctl.imm      = immJ;
                ctl.srcASel  = srcAPc;
                ctl.wbSel    = wbPcPlus4;
                ctl.regWrite = 1'b1;
                ctl.isJump   = 1'b1;
            end
            opcJalr: begin
                ctl.wbSel    = wbPcPlus4;
                ctl.regWrite = 1'b1;
                ctl.isJump   = 1'b1;
            end
            opcLui: begin
                ctl.imm      = immU;
                ctl.wbSel    = wbImm;
                ctl.regWrite = 1'b1;
            end
            opcAuipc: begin
                ctl.imm      = immU;
                ctl.srcASel  = srcAPc;
                ctl.regWrite = 1'b1;
            end
            default: begin
                // unknown opcodes fall through as a no-op
                ctl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* pcUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module pcUnit
    import rvIsaPkg::*, coreCtlPkg::*;
#(
    parameter wordT resetVector = 32'd2048
) (
    input  wire  clk,
    input  wire  rst,
    output wordT pc,
    output wordT pcPlus4,
    input  wordT imm,
    input  wire  branchTaken,
    input  wire  isJal,
    input  wordT jumpTarget,
    input  wire  isJalr
);

    wordT  pcReg;
    wordT  pcPlusImm;
    wordT  pcNextVal;
    pcSelT pcSel;

    assign pc        = pcReg;
    assign pcPlus4   = pcReg + 32'd4;
    assign pcPlusImm = pcReg + imm;

    // taken branches and JAL share the PC-relative adder
    always_comb begin
        if (isJalr) begin
            pcSel = pcJump;
        end else if (branchTaken || isJal) begin
            pcSel = pcBranch;
        end else begin
            pcSel = pcNext;
        end
    end

    always_comb begin
        case (pcSel)
            pcNext:   pcNextVal = pcPlus4;
            pcBranch: pcNextVal = pcPlusImm;
            pcJump:   pcNextVal = jumpTarget;
            default:  pcNextVal = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= resetVector;
        end else begin
            pcReg <= pcNextVal;
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile
    import rvIsaPkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wire     we,
    input  regAddrT waddr,
    input  wordT    wdata,
    input  regAddrT raddr0,
    input  regAddrT raddr1,
    output wordT    rdata0,
    output wordT    rdata1
);

    // x0 has no storage behind it
    wordT regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

/* rv32Core.f */
rvIsaPkg.sv
coreCtlPkg.sv
decodeIf.sv
instrDecoder.sv
regFile.sv
execUnit.sv
pcUnit.sv
rv32Core.sv
tbRv32Core.sv

/* rv32Core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32Core
    import rvIsaPkg::*;
#(
    parameter wordT resetVector = 32'd2048
) (
    input  wire  clk,
    input  wire  rst,
    input  wordT instr,
    output wordT instrAddr,
    output wordT dataAddr,
    output wordT dataWr,
    input  wordT dataRd,
    output logic dataWe,
    output logic dataRe
);

    wordT pc;
    wordT pcPlus4;
    wordT rs1Val;
    wordT rs2Val;
    wordT wbData;
    wordT jumpTarget;
    logic regWe;
    logic branchTaken;
    logic isJal;
    logic isJalr;

    decodeIf ctl ();

    // JAL targets come from the PC adder, JALR targets from the ALU
    assign isJalr    = ctl.isJump && (instr[6:0] == opcJalr);
    assign isJal     = ctl.isJump && !isJalr;
    assign instrAddr = pc;

    instrDecoder instrDecoder_inst (
        .instr (instr),
        .ctl   (ctl.producer)
    );

    regFile regFile_inst (
        .clk    (clk),
        .rst    (rst),
        .we     (regWe),
        .waddr  (ctl.rd),
        .wdata  (wbData),
        .raddr0 (ctl.rs1),
        .raddr1 (ctl.rs2),
        .rdata0 (rs1Val),
        .rdata1 (rs2Val)
    );

    execUnit execUnit_inst (
        .rst         (rst),
        .ctl         (ctl.consumer),
        .pc          (pc),
        .pcPlus4     (pcPlus4),
        .rs1Val      (rs1Val),
        .rs2Val      (rs2Val),
        .dataRd      (dataRd),
        .regWe       (regWe),
        .wbData      (wbData),
        .dataAddr    (dataAddr),
        .dataWr      (dataWr),
        .dataWe      (dataWe),
        .dataRe      (dataRe),
        .branchTaken (branchTaken),
        .jumpTarget  (jumpTarget)
    );

    pcUnit #(
        .resetVector (resetVector)
    ) pcUnit_inst (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .pcPlus4     (pcPlus4),
        .imm         (ctl.imm),
        .branchTaken (branchTaken),
        .isJal       (isJal),
        .jumpTarget  (jumpTarget),
        .isJalr      (isJalr)
    );

endmodule

`default_nettype wire

/* rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;

    // major opcodes of the RV32I base set
    localparam opcodeT opcOp     = 7'b0110011;
    localparam opcodeT opcOpImm  = 7'b0010011;
    localparam opcodeT opcLoad   = 7'b0000011;
    localparam opcodeT opcStore  = 7'b0100011;
    localparam opcodeT opcBranch = 7'b1100011;
    localparam opcodeT opcJal    = 7'b1101111;
    localparam opcodeT opcJalr   = 7'b1100111;
    localparam opcodeT opcLui    = 7'b0110111;
    localparam opcodeT opcAuipc  = 7'b0010111;

    // funct3 for OP and OP-IMM
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // funct3 for the conditional branches
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    // only word-wide loads and stores are supported
    localparam funct3T f3Word = 3'b010;

    // instruction bit 30 turns ADD into SUB and SRL into SRA
    localparam int funct7Alt = 30;

endpackage

`default_nettype wire

/* tbRv32Core.sv */
`timescale 1ns/1ns
`default_nettype none

module tbRv32Core
    import rvIsaPkg::*;
();

    localparam wordT resetAddr   = 32'd2048;
    localparam wordT signBit     = 32'h8000_0000;
    localparam int   resetCycles = 5;

    // one executed instruction with the bus activity it must produce
    typedef struct packed {
        wordT instr;
        wordT pc;
        logic ld;
        logic st;
        wordT addr;
        wordT data;
    } rowT;

    logic clk;
    logic rst;
    wordT instr;
    wordT instrAddr;
    wordT dataAddr;
    wordT dataWr;
    wordT dataRd;
    logic dataWe;
    logic dataRe;

    wordT        instrOffset;
    wordT        imem [256];
    wordT        dmem [256];
    wordT        refMem [256];
    wordT        refRegs [32];
    wordT        refPc;
    wordT        rngState;
    logic [11:0] storeOffset;
    rowT         rows [$];
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    rv32Core rv32Core_inst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .instrAddr (instrAddr),
        .dataAddr  (dataAddr),
        .dataWr    (dataWr),
        .dataRd    (dataRd),
        .dataWe    (dataWe),
        .dataRe    (dataRe)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // both memories answer in the same cycle
    assign instrOffset = instrAddr - resetAddr;
    assign instr       = imem[instrOffset[9:2]];
    assign dataRd      = dmem[dataAddr[9:2]];

    function automatic wordT xorshift32(input wordT s);
        wordT x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word idx of the data memory gets the idx-th value of the sequence
    function automatic wordT dataSeed(input int idx);
        wordT s;
        s = 32'd54909;
        for (int j = 0; j <= idx; j++) begin
            s = xorshift32(s);
        end
        return s;
    endfunction

    initial begin
        for (int k = 0; k < 256; k++) begin
            dmem[k] <= dataSeed(k);
        end
        forever begin
            @(posedge clk);
            if (dataWe) begin
                dmem[dataAddr[9:2]] <= dataWr;
            end
        end
    end

    function automatic wordT encodeR(input logic alt, input funct3T f3, input regAddrT rd,
                                     input regAddrT rs1, input regAddrT rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic wordT encodeI(input opcodeT opc, input funct3T f3, input regAddrT rd,
                                     input regAddrT rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT encodeS(input regAddrT rs1, input regAddrT rs2,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opcStore};
    endfunction

    function automatic wordT encodeB(input funct3T f3, input regAddrT rs1, input regAddrT rs2,
                                     input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic wordT encodeU(input opcodeT opc, input regAddrT rd,
                                     input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic wordT encodeJ(input regAddrT rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    function automatic wordT aluRef(input funct3T f3, input logic alt, input wordT a,
                                    input wordT b);
        logic [63:0] ext;
        wordT        r;
        // arithmetic shift as a logical shift of the sign-extended value
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (f3)
            f3AddSub: r = alt ? a - b : a + b;
            f3Sll:    r = a << b[4:0];
            f3Slt:    r = ((a ^ signBit) < (b ^ signBit)) ? 32'd1 : 32'd0;
            f3Sltu:   r = (a < b) ? 32'd1 : 32'd0;
            f3Xor:    r = a ^ b;
            f3SrlSra: r = alt ? ext[31:0] : a >> b[4:0];
            f3Or:     r = a | b;
            default:  r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchCondition(input funct3T f3, input wordT a, input wordT b);
        case (f3)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return (a ^ signBit) < (b ^ signBit);
            f3Bge:   return (a ^ signBit) >= (b ^ signBit);
            f3Bltu:  return a < b;
            f3Bgeu:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic writeReg(input regAddrT rd, input wordT value);
        if (rd != 5'd0) begin
            refRegs[rd] = value;
        end
    endtask

    // executes one instruction on the model and records a row at the model PC
    task automatic stepReference(input wordT ins);
        rowT     r;
        regAddrT rd;
        funct3T  f3;
        wordT    a;
        wordT    b;
        wordT    immI;
        wordT    immS;
        wordT    immB;
        wordT    immU;
        wordT    immJ;
        wordT    nextPc;
        rd     = ins[11:7];
        f3     = ins[14:12];
        a      = refRegs[ins[19:15]];
        b      = refRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU   = {ins[31:12], 12'h000};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        r       = '0;
        r.instr = ins;
        r.pc    = refPc;
        nextPc  = refPc + 32'd4;
        case (ins[6:0])
            opcOp: begin
                writeReg(rd, aluRef(f3, ins[30], a, b));
            end
            opcOpImm: begin
                writeReg(rd, aluRef(f3, ins[30] && (f3 == f3SrlSra), a, immI));
            end
            opcLoad: begin
                r.ld   = 1'b1;
                r.addr = a + immI;
                writeReg(rd, refMem[r.addr[9:2]]);
            end
            opcStore: begin
                r.st   = 1'b1;
                r.addr = a + immS;
                r.data = b;
                refMem[r.addr[9:2]] = b;
            end
            opcBranch: begin
                if (branchCondition(f3, a, b)) begin
                    nextPc = refPc + immB;
                end
            end
            opcJal: begin
                nextPc = refPc + immJ;
                writeReg(rd, refPc + 32'd4);
            end
            opcJalr: begin
                nextPc = (a + immI) & ~32'd1;
                writeReg(rd, refPc + 32'd4);
            end
            opcLui: begin
                writeReg(rd, immU);
            end
            opcAuipc: begin
                writeReg(rd, refPc + immU);
            end
            default: begin
                nextPc = refPc + 32'd4;
            end
        endcase
        rows.push_back(r);
        refPc = nextPc;
    endtask

    // places every row's instruction at the address it runs from
    task automatic loadProgram();
        wordT offset;
        foreach (rows[i]) begin
            offset = rows[i].pc - resetAddr;
            imem[offset[9:2]] = rows[i].instr;
        end
    endtask

    // results go to consecutive words above the base held in x20
    task automatic storeResult(input regAddrT rs);
        stepReference(encodeS(5'd20, rs, storeOffset));
        storeOffset = storeOffset + 12'd4;
    endtask

    task automatic buildProgram();
        funct3T      f3;
        logic [11:0] imm;
        funct3T      branchKinds [6];
        branchKinds = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        stepReference(encodeI(opcOpImm, f3AddSub, 5'd20, 5'd0, 12'd512));
        for (int k = 0; k < 8; k++) begin
            stepReference(encodeI(opcLoad, f3Word, regAddrT'(k + 1), 5'd0, 12'(4 * k)));
        end
        // eight plain funct3 values, then SUB and SRA
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? funct3T'(k) : ((k == 8) ? f3AddSub : f3SrlSra);
            stepReference(encodeR(k >= 8, f3, 5'd10, regAddrT'(1 + k % 8),
                                  regAddrT'(1 + (k + 3) % 8)));
            storeResult(5'd10);
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? funct3T'(k) : f3SrlSra;
            rngState = xorshift32(rngState);
            if (f3 == f3Sll || f3 == f3SrlSra) begin
                imm = {1'b0, k == 8, 5'b0, rngState[4:0]};
            end else begin
                imm = rngState[11:0];
            end
            stepReference(encodeI(opcOpImm, f3, 5'd11, regAddrT'(1 + k % 8), imm));
            storeResult(5'd11);
        end
        stepReference(encodeI(opcOpImm, f3AddSub, 5'd21, 5'd0, 12'd5));
        stepReference(encodeI(opcOpImm, f3AddSub, 5'd22, 5'd0, 12'hFFD));
        stepReference(encodeI(opcOpImm, f3AddSub, 5'd23, 5'd0, 12'd5));
        // the three operand orders give a taken and a not taken case for every condition
        for (int k = 0; k < 6; k++) begin
            stepReference(encodeB(branchKinds[k], 5'd21, 5'd22, 13'd8));
            stepReference(encodeB(branchKinds[k], 5'd22, 5'd21, 13'd8));
            stepReference(encodeB(branchKinds[k], 5'd21, 5'd23, 13'd8));
        end
        stepReference(encodeJ(5'd24, 21'd12));
        stepReference(encodeU(opcAuipc, 5'd25, 20'd0));
        // odd offset so that bit 0 of the JALR target has to be cleared
        stepReference(encodeI(opcJalr, 3'b000, 5'd26, 5'd25, 12'd13));
        storeResult(5'd24);
        storeResult(5'd26);
        rngState = xorshift32(rngState);
        stepReference(encodeU(opcLui, 5'd27, rngState[31:12]));
        rngState = xorshift32(rngState);
        stepReference(encodeU(opcAuipc, 5'd28, rngState[19:0]));
        stepReference(encodeI(opcOpImm, f3AddSub, 5'd0, 5'd1, 12'h123));
        // custom-0 opcode with rd = x10, must leave x10 alone
        stepReference(32'h0000_550B);
        storeResult(5'd27);
        storeResult(5'd28);
        storeResult(5'd0);
        storeResult(5'd10);
    endtask

    task automatic reportMismatch(input string what, input wordT got, input wordT exp);
        errorCount++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic checkReset();
        checkCount++;
        if (instrAddr !== resetAddr) begin
            reportMismatch("instrAddr in reset", instrAddr, resetAddr);
        end
        if (dataWe !== 1'b0 || dataRe !== 1'b0) begin
            reportMismatch("dataWe/dataRe in reset", {30'b0, dataWe, dataRe}, 32'd0);
        end
    endtask

    task automatic checkRow(input int i);
        rowT   r;
        string tag;
        r   = rows[i];
        tag = $sformatf("row %0d", i);
        checkCount++;
        if (instrAddr !== r.pc) begin
            reportMismatch({tag, " instrAddr"}, instrAddr, r.pc);
        end
        if (dataWe !== r.st) begin
            reportMismatch({tag, " dataWe"}, {31'b0, dataWe}, {31'b0, r.st});
        end
        if (dataRe !== r.ld) begin
            reportMismatch({tag, " dataRe"}, {31'b0, dataRe}, {31'b0, r.ld});
        end
        if ((r.st || r.ld) && dataAddr !== r.addr) begin
            reportMismatch({tag, " dataAddr"}, dataAddr, r.addr);
        end
        if (r.st && dataWr !== r.data) begin
            reportMismatch({tag, " dataWr"}, dataWr, r.data);
        end
    endtask

    initial begin
        rst <= 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k]   = {k[24:0], 7'h7F};
            refMem[k] = dataSeed(k);
        end
        for (int k = 0; k < 32; k++) begin
            refRegs[k] = '0;
        end
        refPc       = resetAddr;
        rngState    = dataSeed(256);
        storeOffset = '0;
        buildProgram();
        loadProgram();
        cycleLimit = rows.size() + resetCycles + 20;
        // a store and then a load sit at the reset vector while rst is high
        imem[0] = encodeS(5'd0, 5'd0, 12'd0);
        repeat (2) begin
            @(negedge clk);
            checkReset();
        end
        imem[0] = encodeI(opcLoad, f3Word, 5'd1, 5'd0, 12'd0);
        repeat (resetCycles - 3) begin
            @(negedge clk);
            checkReset();
        end
        imem[0] = rows[0].instr;
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            checkRow(i);
        end
        $display("%0d checks run, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the program did not run to its end", cycleCount);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
